//--- files.f
+incdir+include
hw/writeback_pkg.sv
hw/writeback_stage.sv
hw/lane_register_bank.sv
hw/operand_read.sv
hw/writeback_subsystem.sv
testbench/writeback_tb.sv

//--- hw/lane_register_bank.sv
// One lane of the register file
// Vector registers for this lane plus a scalar copy, for every thread

`default_nettype none

`include "writeback_defines.svh"

module lane_register_bank(
	input wire clk,
	input wire reset,
	input wire writeback_pkg::wb_write_t wb,
	input wire writeback_pkg::scalar_t lane_value,
	input wire lane_mask,
	input wire writeback_pkg::read_request_t bank_read,
	output writeback_pkg::scalar_t lane_data
);

	import writeback_pkg::*;

	localparam int ENTRIES = `THREADS * `NUM_REGS;
	localparam int ADDR_BITS = $clog2(ENTRIES);

	scalar_t vector_regs[ENTRIES];
	scalar_t scalar_regs[ENTRIES];
	logic [ENTRIES - 1:0] vector_written;
	logic [ENTRIES - 1:0] scalar_written;
	logic [ADDR_BITS - 1:0] write_addr;
	logic [ADDR_BITS - 1:0] read_addr;

	// Entry index is thread then register
	assign write_addr = {wb.thread, wb.reg_idx};
	assign read_addr = {bank_read.thread, bank_read.reg_idx};

	// Storage
	always_ff @(posedge clk)
	begin
		if (wb.en && wb.is_vector && lane_mask)
			vector_regs[write_addr] <= lane_value;

		// Scalar writes land in every bank so the copies agree
		if (wb.en && !wb.is_vector)
			scalar_regs[write_addr] <= lane_value;
	end

	// Written flags, so a register reads zero until first written
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			vector_written <= '0;
			scalar_written <= '0;
		end
		else if (wb.en)
		begin
			if (wb.is_vector && lane_mask)
				vector_written[write_addr] <= 1'b1;
			else if (!wb.is_vector)
				scalar_written[write_addr] <= 1'b1;
		end
	end

	// Registered read, old value on a same-edge write
	always_ff @(posedge clk)
	begin
		if (bank_read.en)
		begin
			if (bank_read.is_vector)
				lane_data <= vector_written[read_addr] ? vector_regs[read_addr] : '0;
			else
				lane_data <= scalar_written[read_addr] ? scalar_regs[read_addr] : '0;
		end
	end

endmodule

`default_nettype wire

//--- hw/operand_read.sv
// Operand read port of the register file
// Gathers lane data, forwards a write landing with the read, replicates scalars

`default_nettype none

`include "writeback_defines.svh"

module operand_read(
	input wire clk,
	input wire reset,
	input wire writeback_pkg::read_request_t rd_req,
	input wire writeback_pkg::wb_write_t wb,
	output writeback_pkg::read_request_t bank_read,
	input wire writeback_pkg::vector_t lane_data,
	output logic rd_valid,
	output writeback_pkg::vector_t rd_data
);

	import writeback_pkg::*;

	logic fwd_match;
	logic fwd_hit;
	logic req_is_vector;
	lane_mask_t fwd_lanes;
	vector_t fwd_value;
	vector_t merged;

	// Banks see the request on the same cycle
	assign bank_read = rd_req;

	// Scalar and vector files are separate, so the kind must match too
	assign fwd_match = rd_req.en && wb.en
		&& wb.thread == rd_req.thread
		&& wb.reg_idx == rd_req.reg_idx
		&& wb.is_vector == rd_req.is_vector;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			rd_valid <= 1'b0;
			fwd_hit <= 1'b0;
		end
		else
		begin
			rd_valid <= rd_req.en;
			fwd_hit <= fwd_match;
		end
	end

	// Request kind and forwarded data
	always_ff @(posedge clk)
	begin
		if (rd_req.en)
		begin
			req_is_vector <= rd_req.is_vector;
			fwd_value <= wb.value;
			// Scalar write covers every lane
			fwd_lanes <= wb.is_vector ? wb.mask : '1;
		end
	end

	// Replace forwarded lanes
	always_comb
	begin
		for (int lane = 0; lane < `VECTOR_LANES; lane++)
			merged[lane] = (fwd_hit && fwd_lanes[lane]) ? fwd_value[lane] : lane_data[lane];
	end

	assign rd_data = req_is_vector ? merged : {`VECTOR_LANES{merged[0]}};

endmodule

`default_nettype wire

//--- hw/writeback_pkg.sv
// Types shared by the writeback stage, the lane banks and the operand read block
// Vector layout, memory operation encodings and the structs between blocks

`default_nettype none

`include "writeback_defines.svh"

package writeback_pkg;

	typedef logic [31:0] scalar_t;

	// Lane k sits in bits k*32 upward
	typedef scalar_t [`VECTOR_LANES - 1:0] vector_t;

	typedef logic [`VECTOR_LANES - 1:0] lane_mask_t;
	typedef logic [$clog2(`THREADS) - 1:0] thread_idx_t;
	typedef logic [4:0] register_idx_t;

	// Byte at offset 0 is the top byte of the line
	typedef logic [`CACHE_LINE_BYTES * 8 - 1:0] cache_line_t;

	typedef enum logic [2:0] {
		MEM_B,
		MEM_BX,
		MEM_S,
		MEM_SX,
		MEM_L,
		MEM_BLOCK
	} mem_op_t;

	typedef enum logic {
		PIPE_SCYCLE_ARITH,
		PIPE_MEM
	} pipeline_sel_t;

	// Decoded fields that writeback needs
	typedef struct packed {
		logic has_dest;
		register_idx_t dest_reg;
		logic dest_is_vector;
		logic is_vector_compare;
		logic is_load;
		mem_op_t memory_access_type;
		scalar_t pc;
	} decoded_instruction_t;

	// Single-cycle arithmetic pipe result
	typedef struct packed {
		logic valid;
		decoded_instruction_t instruction;
		vector_t result;
		thread_idx_t thread;
		lane_mask_t mask;
		logic rollback_en;
		thread_idx_t rollback_thread;
		scalar_t rollback_pc;
	} sc_result_t;

	// Data cache pipe result, line data arrives separately
	typedef struct packed {
		logic valid;
		decoded_instruction_t instruction;
		lane_mask_t mask;
		thread_idx_t thread;
		scalar_t request_addr;
	} dd_result_t;

	typedef struct packed {
		logic en;
		thread_idx_t thread;
		scalar_t pc;
		pipeline_sel_t source;
	} rollback_t;

	// Register file write port
	typedef struct packed {
		logic en;
		thread_idx_t thread;
		logic is_vector;
		vector_t value;
		lane_mask_t mask;
		register_idx_t reg_idx;
	} wb_write_t;

	// Register file read port
	typedef struct packed {
		logic en;
		thread_idx_t thread;
		register_idx_t reg_idx;
		logic is_vector;
	} read_request_t;

endpackage

`default_nettype wire

//--- hw/writeback_stage.sv
// Writeback stage
// Selects the arithmetic or cache result, aligns scalar loads, swaps block loads,
// packs vector compares and raises rollback on PC writes

`default_nettype none

`include "writeback_defines.svh"

module writeback_stage(
	input wire clk,
	input wire reset,
	input wire writeback_pkg::sc_result_t sc,
	input wire writeback_pkg::dd_result_t dd,
	input wire writeback_pkg::cache_line_t dcache_data,
	output writeback_pkg::rollback_t rollback,
	output writeback_pkg::wb_write_t wb
);

	import writeback_pkg::*;

	localparam int LINE_WORDS = `CACHE_LINE_BYTES / 4;
	localparam int WORD_IDX_BITS = $clog2(LINE_WORDS);

	mem_op_t mem_op;
	logic [WORD_IDX_BITS - 1:0] word_sel;
	logic [WORD_IDX_BITS - 1:0] chunk_sel;
	scalar_t load_chunk;
	logic [7:0] load_byte;
	logic [15:0] load_half;
	scalar_t load_scalar;
	vector_t block_value;
	lane_mask_t compare_bits;
	vector_t sc_value;
	wb_write_t wb_next;

	// Swap a line chunk into a little-endian word
	function automatic scalar_t byte_swap(input scalar_t chunk);
		byte_swap = {chunk[7:0], chunk[15:8], chunk[23:16], chunk[31:24]};
	endfunction

	// Rollback must be seen this cycle so younger instructions are squashed
	always_comb
	begin
		rollback.en = 1'b0;
		rollback.thread = '0;
		rollback.pc = '0;
		rollback.source = PIPE_SCYCLE_ARITH;
		if (sc.valid && sc.instruction.has_dest && sc.instruction.dest_reg == `REG_PC)
		begin
			// Jump by writing PC, new PC is lane 0 of the result
			rollback.en = 1'b1;
			rollback.thread = sc.thread;
			rollback.pc = sc.result[0];
		end
		else if (sc.valid)
		begin
			// Branch resolution from the arithmetic pipe
			rollback.en = sc.rollback_en;
			rollback.thread = sc.rollback_thread;
			rollback.pc = sc.rollback_pc;
		end
	end

	assign mem_op = dd.instruction.memory_access_type;

	// Word offset 0 is the top chunk of the line
	assign word_sel = dd.request_addr[2 +: WORD_IDX_BITS];
	assign chunk_sel = ~word_sel;
	assign load_chunk = dcache_data[chunk_sel * 32 +: 32];

	// Byte 0 of the word sits in the chunk's top byte
	always_comb
	begin
		case (dd.request_addr[1:0])
			2'd0: load_byte = load_chunk[31:24];
			2'd1: load_byte = load_chunk[23:16];
			2'd2: load_byte = load_chunk[15:8];
			default: load_byte = load_chunk[7:0];
		endcase
	end

	// Halfword, low byte from the lower offset
	always_comb
	begin
		if (dd.request_addr[1])
			load_half = {load_chunk[7:0], load_chunk[15:8]};
		else
			load_half = {load_chunk[23:16], load_chunk[31:24]};
	end

	// Width and sign extension
	always_comb
	begin
		case (mem_op)
			MEM_B: load_scalar = {24'd0, load_byte};
			MEM_BX: load_scalar = {{24{load_byte[7]}}, load_byte};
			MEM_S: load_scalar = {16'd0, load_half};
			MEM_SX: load_scalar = {{16{load_half[15]}}, load_half};
			default: load_scalar = byte_swap(load_chunk);
		endcase
	end

	// Block load, lane k takes the word at offset 4*(lanes-1-k)
	for (genvar lane = 0; lane < `VECTOR_LANES; lane++)
	begin : block_swap
		localparam int CHUNK = LINE_WORDS - `VECTOR_LANES + lane;
		assign block_value[lane] = byte_swap(dcache_data[CHUNK * 32 +: 32]);
	end

	// Compare bitmap, bit k from lane k
	for (genvar lane = 0; lane < `VECTOR_LANES; lane++)
	begin : compare_pack
		assign compare_bits[lane] = sc.result[lane][0];
	end

	always_comb
	begin
		if (sc.instruction.is_vector_compare)
		begin
			sc_value = '0;
			sc_value[0] = scalar_t'(compare_bits);
		end
		else
			sc_value = sc.result;

		// Scalar destinations carry lane 0 in every lane
		if (!sc.instruction.dest_is_vector)
			sc_value = {`VECTOR_LANES{sc_value[0]}};
	end

	// Source select, arithmetic first
	always_comb
	begin
		wb_next = '0;
		if (sc.valid)
		begin
			wb_next.en = sc.instruction.has_dest && !rollback.en;
			wb_next.thread = sc.thread;
			wb_next.is_vector = sc.instruction.dest_is_vector;
			wb_next.value = sc_value;
			wb_next.mask = sc.mask;
			wb_next.reg_idx = sc.instruction.dest_reg;
		end
		else if (dd.valid)
		begin
			// Stores pass through without a write
			wb_next.en = dd.instruction.has_dest && dd.instruction.is_load;
			wb_next.thread = dd.thread;
			wb_next.is_vector = dd.instruction.dest_is_vector;
			wb_next.reg_idx = dd.instruction.dest_reg;
			if (mem_op == MEM_BLOCK)
			begin
				wb_next.value = block_value;
				wb_next.mask = dd.mask;
			end
			else
			begin
				wb_next.value = {`VECTOR_LANES{load_scalar}};
				wb_next.mask = '1;
			end
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			wb <= '0;
		else
			wb <= wb_next;
	end

endmodule

`default_nettype wire

//--- hw/writeback_subsystem.sv
// Writeback subsystem top level
// Writeback stage feeding a row of lane register banks and the operand read port

`default_nettype none

`include "writeback_defines.svh"

module writeback_subsystem(
	input wire clk,
	input wire reset,
	input wire writeback_pkg::sc_result_t sc,
	input wire writeback_pkg::dd_result_t dd,
	input wire writeback_pkg::cache_line_t dcache_data,
	output writeback_pkg::rollback_t rollback,
	output writeback_pkg::wb_write_t wb,
	input wire writeback_pkg::read_request_t rd_req,
	output logic rd_valid,
	output writeback_pkg::vector_t rd_data
);

	import writeback_pkg::*;

	read_request_t bank_read;
	vector_t lane_data;

	writeback_stage writeback_stage_inst(
		.clk(clk),
		.reset(reset),
		.sc(sc),
		.dd(dd),
		.dcache_data(dcache_data),
		.rollback(rollback),
		.wb(wb)
	);

	// One bank per lane, each takes its own slice of value and mask
	for (genvar lane = 0; lane < `VECTOR_LANES; lane++)
	begin : lane_bank
		lane_register_bank lane_register_bank_inst(
			.clk(clk),
			.reset(reset),
			.wb(wb),
			.lane_value(wb.value[lane]),
			.lane_mask(wb.mask[lane]),
			.bank_read(bank_read),
			.lane_data(lane_data[lane])
		);
	end

	operand_read operand_read_inst(
		.clk(clk),
		.reset(reset),
		.rd_req(rd_req),
		.wb(wb),
		.bank_read(bank_read),
		.lane_data(lane_data),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

endmodule

`default_nettype wire

//--- include/writeback_defines.svh
// Shared sizing macros for the writeback path and register file
// Lane, thread and register counts used by every block

`ifndef WRITEBACK_DEFINES_SVH
`define WRITEBACK_DEFINES_SVH

// Number of vector lanes
`define VECTOR_LANES 4

// Hardware threads sharing the register file
`define THREADS 4

// Registers per file, scalar and vector alike
`define NUM_REGS 32

// Writing this register redirects the thread
`define REG_PC 31

// One 32-bit word per lane in a cache line
`define CACHE_LINE_BYTES 16

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# Build the writeback subsystem testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module writeback_tb \
	-Mdir obj_dir \
	-f files.f

output="$(./obj_dir/Vwriteback_tb)"
echo "$output"

if grep -qx "all tests passed" <<< "$output"; then
	echo "Simulation PASSED"
	exit 0
else
	echo "Simulation FAILED"
	exit 1
fi

//--- testbench/writeback_tb.sv
// Testbench for the writeback subsystem
// Random arithmetic, compare, rollback and load traffic checked against a shadow register file

`default_nettype none

`include "writeback_defines.svh"

module writeback_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import writeback_pkg::*;

	typedef logic [127:0] wide_t;

	// Operation counts per test that also size the watchdog
	localparam int N_ARITH = 24;
	localparam int N_CMP = 8;
	localparam int N_ROLL = 4;
	localparam int LOAD_OPS = 52;
	localparam int N_BLOCK = 6;
	localparam int N_FWD = 6;
	localparam int N_BOTH = 4;
	localparam int TOTAL_CYCLES = 6 + 2 * N_ARITH + 2 * N_CMP + 4 * N_ROLL + 2 * LOAD_OPS
		+ 2 * N_BLOCK + 2 + 2 * N_FWD + 2 * N_BOTH;
	localparam int MARGIN_CYCLES = 100;

	logic clk;
	logic reset;
	sc_result_t sc;
	dd_result_t dd;
	cache_line_t dcache_data;
	rollback_t rollback;
	wb_write_t wb;
	read_request_t rd_req;
	logic rd_valid;
	vector_t rd_data;

	// Shadow register file
	scalar_t vec_model[`THREADS][`NUM_REGS][`VECTOR_LANES];
	scalar_t scal_model[`THREADS][`NUM_REGS];

	int error_count = 0;
	int test_errors_before = 0;
	int tests_run = 0;
	int tests_bad = 0;

	writeback_subsystem writeback_subsystem_inst(
		.clk(clk),
		.reset(reset),
		.sc(sc),
		.dd(dd),
		.dcache_data(dcache_data),
		.rollback(rollback),
		.wb(wb),
		.rd_req(rd_req),
		.rd_valid(rd_valid),
		.rd_data(rd_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Ends a stuck run after all stimulus cycles plus slack
	initial
	begin
		#((TOTAL_CYCLES + MARGIN_CYCLES) * 40);
		$display("watchdog expired before the last test completed");
		$display("tests failed");
		$finish;
	end

	task automatic mismatch(input string name, input wide_t got, input wide_t expected);
		$display("** Error %s: got %0h expected %0h", name, got, expected);
		error_count++;
	endtask

	task automatic finish_test(input int num, input string name);
		tests_run++;
		if (error_count == test_errors_before)
			$display("test %0d %s: ok", num, name);
		else
		begin
			tests_bad++;
			$display("test %0d %s: %0d errors", num, name, error_count - test_errors_before);
		end
		test_errors_before = error_count;
	endtask

	// Offset 0 is the top byte of the line
	function automatic logic [7:0] line_byte(input cache_line_t line, input int offset);
		return line[(`CACHE_LINE_BYTES - 1 - offset) * 8 +: 8];
	endfunction

	// Little-endian word starting at an offset
	function automatic scalar_t line_word(input cache_line_t line, input int offset);
		return {line_byte(line, offset + 3), line_byte(line, offset + 2),
			line_byte(line, offset + 1), line_byte(line, offset)};
	endfunction

	function automatic rollback_t predict_rollback(input sc_result_t s);
		rollback_t r;
		r = '0;
		r.source = PIPE_SCYCLE_ARITH;
		if (s.valid && s.instruction.has_dest
			&& s.instruction.dest_reg == register_idx_t'(`REG_PC))
		begin
			r.en = 1'b1;
			r.thread = s.thread;
			r.pc = s.result[0];
		end
		else if (s.valid)
		begin
			r.en = s.rollback_en;
			r.thread = s.rollback_thread;
			r.pc = s.rollback_pc;
		end
		return r;
	endfunction

	function automatic wb_write_t predict_sc(input sc_result_t s);
		wb_write_t w;
		rollback_t r;
		w = '0;
		r = predict_rollback(s);
		// Suppressed by any rollback in the same cycle
		if (!s.instruction.has_dest || r.en)
			return w;
		w.en = 1'b1;
		w.thread = s.thread;
		w.is_vector = s.instruction.dest_is_vector;
		w.reg_idx = s.instruction.dest_reg;
		w.mask = s.mask;
		w.value = s.result;
		if (s.instruction.is_vector_compare)
		begin
			w.value = '0;
			for (int k = 0; k < `VECTOR_LANES; k++)
				w.value[0][k] = s.result[k][0];
		end
		if (!w.is_vector)
			for (int k = 1; k < `VECTOR_LANES; k++)
				w.value[k] = w.value[0];
		return w;
	endfunction

	function automatic wb_write_t predict_dd(input dd_result_t d, input cache_line_t line);
		wb_write_t w;
		scalar_t s;
		int offset;
		w = '0;
		if (!d.instruction.is_load || !d.instruction.has_dest)
			return w;
		offset = int'(d.request_addr[3:0]);
		w.en = 1'b1;
		w.thread = d.thread;
		w.is_vector = d.instruction.dest_is_vector;
		w.reg_idx = d.instruction.dest_reg;
		w.mask = '1;
		case (d.instruction.memory_access_type)
			MEM_B: s = scalar_t'(line_byte(line, offset));
			MEM_BX: s = scalar_t'(signed'(line_byte(line, offset)));
			MEM_S: s = scalar_t'({line_byte(line, offset + 1), line_byte(line, offset)});
			MEM_SX: s = scalar_t'(signed'({line_byte(line, offset + 1), line_byte(line, offset)}));
			default: s = line_word(line, offset);
		endcase
		for (int k = 0; k < `VECTOR_LANES; k++)
			w.value[k] = s;
		if (d.instruction.memory_access_type == MEM_BLOCK)
		begin
			w.mask = d.mask;
			for (int k = 0; k < `VECTOR_LANES; k++)
				w.value[k] = line_word(line, 4 * (`VECTOR_LANES - 1 - k));
		end
		return w;
	endfunction

	function automatic void commit(input wb_write_t w);
		if (!w.en)
			return;
		for (int k = 0; k < `VECTOR_LANES; k++)
			if (w.is_vector && w.mask[k])
				vec_model[w.thread][w.reg_idx][k] = w.value[k];
		if (!w.is_vector)
			scal_model[w.thread][w.reg_idx] = w.value[0];
	endfunction

	function automatic vector_t model_read(input read_request_t r);
		vector_t v;
		for (int k = 0; k < `VECTOR_LANES; k++)
			v[k] = r.is_vector ? vec_model[r.thread][r.reg_idx][k]
				: scal_model[r.thread][r.reg_idx];
		return v;
	endfunction

	function automatic read_request_t make_read(input thread_idx_t thread,
		input register_idx_t reg_idx, input logic is_vector);
		read_request_t r;
		r = '0;
		r.en = 1'b1;
		r.thread = thread;
		r.reg_idx = reg_idx;
		r.is_vector = is_vector;
		return r;
	endfunction

	function automatic cache_line_t random_line();
		cache_line_t l;
		for (int i = 0; i < `CACHE_LINE_BYTES / 4; i++)
			l[i * 32 +: 32] = $urandom;
		return l;
	endfunction

	// Register 31 is the PC and stays out
	function automatic sc_result_t random_sc(input logic is_vector);
		sc_result_t s;
		s = '0;
		s.valid = 1'b1;
		s.instruction.has_dest = 1'b1;
		s.instruction.dest_reg = register_idx_t'($urandom % 31);
		s.instruction.dest_is_vector = is_vector;
		s.instruction.pc = $urandom;
		s.thread = thread_idx_t'($urandom);
		s.mask = lane_mask_t'($urandom);
		for (int k = 0; k < `VECTOR_LANES; k++)
			s.result[k] = $urandom;
		return s;
	endfunction

	function automatic dd_result_t make_load(input mem_op_t op, input int offset);
		dd_result_t d;
		d = '0;
		d.valid = 1'b1;
		d.instruction.has_dest = 1'b1;
		d.instruction.is_load = 1'b1;
		d.instruction.dest_is_vector = (op == MEM_BLOCK);
		d.instruction.memory_access_type = op;
		d.instruction.dest_reg = register_idx_t'($urandom % 31);
		d.thread = thread_idx_t'($urandom);
		d.mask = lane_mask_t'($urandom);
		d.request_addr = ($urandom & 32'hffff_fff0) | scalar_t'(offset);
		return d;
	endfunction

	task automatic check_wb(input wb_write_t e);
		assert (wb.en == e.en) else mismatch("wb.en", wide_t'(wb.en), wide_t'(e.en));
		if (e.en)
		begin
			assert (wb.thread == e.thread)
				else mismatch("wb.thread", wide_t'(wb.thread), wide_t'(e.thread));
			assert (wb.is_vector == e.is_vector)
				else mismatch("wb.is_vector", wide_t'(wb.is_vector), wide_t'(e.is_vector));
			assert (wb.reg_idx == e.reg_idx)
				else mismatch("wb.reg_idx", wide_t'(wb.reg_idx), wide_t'(e.reg_idx));
			assert (wb.value == e.value)
				else mismatch("wb.value", wide_t'(wb.value), wide_t'(e.value));
			assert (wb.mask == e.mask)
				else mismatch("wb.mask", wide_t'(wb.mask), wide_t'(e.mask));
		end
	endtask

	// One input cycle with rollback checked mid-cycle and wb after the edge
	task automatic apply(input sc_result_t s, input dd_result_t d, input cache_line_t line);
		rollback_t exp_rb;
		wb_write_t exp_wb;
		exp_rb = predict_rollback(s);
		if (s.valid)
			exp_wb = predict_sc(s);
		else if (d.valid)
			exp_wb = predict_dd(d, line);
		else
			exp_wb = '0;
		@(negedge clk);
		sc = s;
		dd = d;
		dcache_data = line;
		rd_req = '0;
		#5;
		assert (rollback.en == exp_rb.en)
			else mismatch("rollback.en", wide_t'(rollback.en), wide_t'(exp_rb.en));
		if (exp_rb.en)
		begin
			assert (rollback.thread == exp_rb.thread)
				else mismatch("rollback.thread", wide_t'(rollback.thread), wide_t'(exp_rb.thread));
			assert (rollback.pc == exp_rb.pc)
				else mismatch("rollback.pc", wide_t'(rollback.pc), wide_t'(exp_rb.pc));
			assert (rollback.source == exp_rb.source)
				else mismatch("rollback.source", wide_t'(rollback.source), wide_t'(exp_rb.source));
		end
		@(posedge clk);
		#1;
		check_wb(exp_wb);
		// No request this cycle, so the read pulse must have ended
		assert (rd_valid == 1'b0) else mismatch("rd_valid", wide_t'(rd_valid), '0);
		commit(exp_wb);
	endtask

	// One-cycle read where a write in flight must show up
	task automatic read_check(input read_request_t r);
		vector_t expected;
		expected = model_read(r);
		@(negedge clk);
		sc = '0;
		dd = '0;
		rd_req = r;
		@(posedge clk);
		#1;
		assert (rd_valid == 1'b1) else mismatch("rd_valid", wide_t'(rd_valid), wide_t'(1'b1));
		assert (rd_data == expected) else mismatch("rd_data", wide_t'(rd_data), wide_t'(expected));
	endtask

	initial
	begin
		sc_result_t s;
		dd_result_t d;
		read_request_t written[$];
		int step;

		void'($urandom(39));
		for (int t = 0; t < `THREADS; t++)
			for (int r = 0; r < `NUM_REGS; r++)
			begin
				scal_model[t][r] = '0;
				for (int k = 0; k < `VECTOR_LANES; k++)
					vec_model[t][r][k] = '0;
			end
		reset = 1'b1;
		sc = '0;
		dd = '0;
		dcache_data = '0;
		rd_req = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		assert (wb.en == 1'b0) else mismatch("wb.en", wide_t'(wb.en), '0);
		assert (rd_valid == 1'b0) else mismatch("rd_valid", wide_t'(rd_valid), '0);

		// Writes first and reads later from the settled file
		for (int i = 0; i < N_ARITH; i++)
		begin
			s = random_sc(1'($urandom));
			apply(s, '0, dcache_data);
			written.push_back(make_read(s.thread, s.instruction.dest_reg,
				s.instruction.dest_is_vector));
		end
		foreach (written[i])
			read_check(written[i]);
		finish_test(1, "arithmetic writes");

		for (int i = 0; i < N_CMP; i++)
		begin
			s = random_sc(1'b1);
			s.instruction.is_vector_compare = 1'b1;
			s.mask = '1;
			apply(s, '0, dcache_data);
			read_check(make_read(s.thread, s.instruction.dest_reg, 1'b1));
		end
		finish_test(2, "vector compares");

		// PC writes alternate with pipe-requested rollbacks
		for (int i = 0; i < N_ROLL; i++)
		begin
			s = random_sc(1'($urandom));
			s.instruction.dest_reg = register_idx_t'(`REG_PC);
			apply(s, '0, dcache_data);
			read_check(make_read(s.thread, s.instruction.dest_reg, s.instruction.dest_is_vector));
			s = random_sc(1'($urandom));
			s.rollback_en = 1'b1;
			s.rollback_thread = thread_idx_t'($urandom);
			s.rollback_pc = $urandom;
			apply(s, '0, dcache_data);
			read_check(make_read(s.thread, s.instruction.dest_reg, s.instruction.dest_is_vector));
		end
		finish_test(3, "rollback");

		// Bytes at every offset and aligned halfwords and words
		for (int op = 0; op < 5; op++)
		begin
			step = (op < 2) ? 1 : ((op < 4) ? 2 : 4);
			for (int offset = 0; offset < `CACHE_LINE_BYTES; offset += step)
			begin
				d = make_load(mem_op_t'(op), offset);
				apply('0, d, random_line());
				read_check(make_read(d.thread, d.instruction.dest_reg, 1'b0));
			end
		end
		finish_test(4, "scalar loads");

		for (int i = 0; i < N_BLOCK; i++)
		begin
			d = make_load(MEM_BLOCK, 0);
			apply('0, d, random_line());
			read_check(make_read(d.thread, d.instruction.dest_reg, 1'b1));
		end
		// Store with a destination field writes nothing
		d = make_load(MEM_L, 0);
		d.instruction.is_load = 1'b0;
		apply('0, d, random_line());
		read_check(make_read(d.thread, d.instruction.dest_reg, 1'b0));
		finish_test(5, "block loads and store");

		// Read lands while wb.en is high for the same register
		for (int i = 0; i < N_FWD; i++)
		begin
			s = random_sc(1'($urandom));
			apply(s, '0, dcache_data);
			read_check(make_read(s.thread, s.instruction.dest_reg, s.instruction.dest_is_vector));
		end
		// Both sources valid with dd as a store
		for (int i = 0; i < N_BOTH; i++)
		begin
			s = random_sc(1'($urandom));
			d = make_load(MEM_L, 4);
			d.instruction.is_load = 1'b0;
			d.instruction.has_dest = 1'b0;
			apply(s, d, random_line());
			read_check(make_read(s.thread, s.instruction.dest_reg, s.instruction.dest_is_vector));
		end
		finish_test(6, "forwarding and priority");

		@(negedge clk);
		sc = '0;
		dd = '0;
		rd_req = '0;
		repeat (2) @(posedge clk);
		$display("%0d of %0d tests clean, %0d errors", tests_run - tests_bad, tests_run,
			error_count);
		if (error_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire
